/* la_isa_pkg.sv */
`default_nettype none

package la_isa_pkg;

    localparam int XLEN = 32;
    localparam int UOP_W = 8;
    localparam int COND_W = 4;

    typedef logic [XLEN-1:0] word_t;  // operands and immediates
    typedef logic [XLEN-1:0] addr_t;  // instruction addresses
    typedef logic [UOP_W-1:0] uop_t;

    // micro-op layout: [7] branch flag, [6:3] condition, [2:0] other units
    localparam int UOP_BR_BIT = 7;
    localparam int UOP_COND_LSB = 3;

    typedef enum logic [COND_W-1:0] {
        NONE = 4'b0000,
        JIRL = 4'b0011,
        B    = 4'b0100,
        BL   = 4'b0101,
        BEQ  = 4'b0110,
        BNE  = 4'b0111,
        BLT  = 4'b1000,
        BGE  = 4'b1001,
        BLTU = 4'b1010,
        BGEU = 4'b1011
    } br_cond_e;

endpackage

`default_nettype wire

/* bru_pkg.sv */
`default_nettype none

package bru_pkg;

    typedef logic [1:0] bp_ctr_t;  // two-bit saturating counter

    localparam bp_ctr_t CTR_WEAK_TAKEN = 2'd2;
    localparam bp_ctr_t CTR_MAX = 2'd3;
    localparam bp_ctr_t CTR_MIN = 2'd0;

    typedef struct packed {
        la_isa_pkg::addr_t pc;
        la_isa_pkg::word_t imm;
        la_isa_pkg::word_t sr1;
        la_isa_pkg::word_t sr2;
        la_isa_pkg::uop_t  uop;
        logic              pred_taken;   // fetch-side guess
        la_isa_pkg::addr_t pred_target;
    } br_req_t;

    typedef struct packed {
        la_isa_pkg::addr_t pc;
        logic              is_branch;
        logic              taken;
        la_isa_pkg::addr_t target;
        logic              dir_fail;
        logic              addr_fail;
    } br_res_t;

    typedef struct packed {
        br_res_t           res;
        logic              redirect;
        la_isa_pkg::addr_t redirect_pc;
    } br_out_t;

    typedef struct packed {
        logic              hit;
        logic              taken;
        la_isa_pkg::addr_t target;
    } bp_pred_t;

    typedef struct packed {
        la_isa_pkg::addr_t pc;
        logic              taken;
        la_isa_pkg::addr_t target;
    } bp_upd_t;

endpackage

`default_nettype wire

/* branch_unit.sv */
`default_nettype none

module branch_unit (
    input  bru_pkg::br_req_t req,
    output bru_pkg::br_res_t res
);

    la_isa_pkg::br_cond_e cond;
    la_isa_pkg::word_t    offs;
    la_isa_pkg::addr_t    base;
    la_isa_pkg::addr_t    target;
    logic                 is_branch;
    logic                 eq;
    logic                 lt_u;
    logic                 lt_s;
    logic                 cond_met;
    logic                 taken;

    assign cond = la_isa_pkg::br_cond_e'(
        req.uop[la_isa_pkg::UOP_COND_LSB +: la_isa_pkg::COND_W]);
    assign is_branch = req.uop[la_isa_pkg::UOP_BR_BIT];

    assign eq   = (req.sr1 == req.sr2);
    assign lt_u = (req.sr1 < req.sr2);
    // signs differ -> the negative one is smaller
    assign lt_s = (req.sr1[31] != req.sr2[31]) ? req.sr1[31] : lt_u;

    always_comb begin
        case (cond)
            la_isa_pkg::JIRL,
            la_isa_pkg::B,
            la_isa_pkg::BL:   cond_met = 1'b1;
            la_isa_pkg::BEQ:  cond_met = eq;
            la_isa_pkg::BNE:  cond_met = ~eq;
            la_isa_pkg::BLT:  cond_met = lt_s;
            la_isa_pkg::BGE:  cond_met = ~lt_s;
            la_isa_pkg::BLTU: cond_met = lt_u;
            la_isa_pkg::BGEU: cond_met = ~lt_u;
            default:          cond_met = 1'b0;
        endcase
    end

    assign taken = is_branch & cond_met;

    assign offs   = {req.imm[29:0], 2'b00};  // word offset
    assign base   = (cond == la_isa_pkg::JIRL) ? req.sr1 : req.pc;
    assign target = base + offs;

    // direction error takes precedence over target error
    always_comb begin
        if (taken ^ req.pred_taken) begin
            res.dir_fail  = 1'b1;
            res.addr_fail = 1'b1;
        end else if (taken && req.pred_taken && (req.pred_target != target)) begin
            res.dir_fail  = 1'b0;
            res.addr_fail = 1'b1;
        end else begin
            res.dir_fail  = 1'b0;
            res.addr_fail = 1'b0;
        end
    end

    assign res.pc        = req.pc;
    assign res.is_branch = is_branch;
    assign res.taken     = taken;
    assign res.target    = target;

endmodule

`default_nettype wire

/* redirect_ctrl.sv */
`default_nettype none

module redirect_ctrl (
    input  logic             clk,
    input  logic             rst,
    input  logic             in_valid,
    output logic             in_ready,
    input  bru_pkg::br_res_t in_res,
    output logic             out_valid,
    input  logic             out_ready,
    output bru_pkg::br_out_t out,
    output logic             upd_valid,
    output bru_pkg::bp_upd_t upd
);

    bru_pkg::br_out_t  nxt;
    la_isa_pkg::addr_t seq_pc;

    assign seq_pc = in_res.pc + 32'd4;  // fall-through

    assign nxt.res         = in_res;
    assign nxt.redirect    = in_res.dir_fail | in_res.addr_fail;
    assign nxt.redirect_pc = in_res.taken ? in_res.target : seq_pc;

    // empty or draining this cycle
    assign in_ready = ~out_valid | out_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            out <= nxt;
        end
    end

    // train once per branch, on output transfer
    assign upd_valid = out_valid & out_ready & out.res.is_branch;

    assign upd.pc     = out.res.pc;
    assign upd.taken  = out.res.taken;
    assign upd.target = out.res.target;

endmodule

`default_nettype wire

/* branch_predictor.sv */
`default_nettype none

module branch_predictor #(
    parameter int BTB_ENTRIES = 16
) (
    input  logic              clk,
    input  logic              rst,
    input  la_isa_pkg::addr_t fetch_pc,
    output bru_pkg::bp_pred_t fetch_pred,
    input  logic              upd_valid,
    input  bru_pkg::bp_upd_t  upd
);

    localparam int IDX_W = $clog2(BTB_ENTRIES);
    localparam int TAG_W = la_isa_pkg::XLEN - IDX_W - 2;

    typedef logic [IDX_W-1:0] idx_t;
    typedef logic [TAG_W-1:0] tag_t;

    logic [BTB_ENTRIES-1:0] valid;
    tag_t                   tags [BTB_ENTRIES];
    la_isa_pkg::addr_t      tgts [BTB_ENTRIES];
    bru_pkg::bp_ctr_t       ctrs [BTB_ENTRIES];

    idx_t f_idx;
    tag_t f_tag;
    logic f_hit;
    idx_t u_idx;
    tag_t u_tag;
    logic u_hit;

    // lookup
    assign f_idx = fetch_pc[IDX_W+1:2];
    assign f_tag = fetch_pc[la_isa_pkg::XLEN-1:IDX_W+2];
    assign f_hit = valid[f_idx] && (tags[f_idx] == f_tag);

    assign fetch_pred.hit    = f_hit;
    assign fetch_pred.taken  = f_hit && ctrs[f_idx][1];  // counter >= 2
    assign fetch_pred.target = tgts[f_idx];

    // update
    assign u_idx = upd.pc[IDX_W+1:2];
    assign u_tag = upd.pc[la_isa_pkg::XLEN-1:IDX_W+2];
    assign u_hit = valid[u_idx] && (tags[u_idx] == u_tag);

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= '0;
        end else if (upd_valid && !u_hit && upd.taken) begin
            valid[u_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (upd_valid) begin
            if (u_hit) begin
                if (upd.taken) begin
                    tgts[u_idx] <= upd.target;
                    if (ctrs[u_idx] != bru_pkg::CTR_MAX) begin
                        ctrs[u_idx] <= ctrs[u_idx] + 2'd1;
                    end
                end else if (ctrs[u_idx] != bru_pkg::CTR_MIN) begin
                    ctrs[u_idx] <= ctrs[u_idx] - 2'd1;
                end
            end else if (upd.taken) begin  // allocate weak taken
                tags[u_idx] <= u_tag;
                tgts[u_idx] <= upd.target;
                ctrs[u_idx] <= bru_pkg::CTR_WEAK_TAKEN;
            end
        end
    end

endmodule

`default_nettype wire

/* bru_top.sv */
`default_nettype none

module bru_top #(
    parameter int BTB_ENTRIES = 16
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              req_valid,
    output logic              req_ready,
    input  bru_pkg::br_req_t  req,
    output logic              res_valid,
    input  logic              res_ready,
    output bru_pkg::br_out_t  res,
    input  la_isa_pkg::addr_t fetch_pc,
    output bru_pkg::bp_pred_t fetch_pred
);

    bru_pkg::br_res_t resolved;
    logic             upd_valid;
    bru_pkg::bp_upd_t upd;

    branch_unit u_branch_unit (
        .req (req),
        .res (resolved)
    );

    redirect_ctrl u_redirect_ctrl (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (req_valid),
        .in_ready  (req_ready),
        .in_res    (resolved),
        .out_valid (res_valid),
        .out_ready (res_ready),
        .out       (res),
        .upd_valid (upd_valid),
        .upd       (upd)
    );

    branch_predictor #(
        .BTB_ENTRIES (BTB_ENTRIES)
    ) u_branch_predictor (
        .clk        (clk),
        .rst        (rst),
        .fetch_pc   (fetch_pc),
        .fetch_pred (fetch_pred),
        .upd_valid  (upd_valid),
        .upd        (upd)
    );

endmodule

`default_nettype wire

/* bru_chk.sv */
`default_nettype none

module bru_chk (
    input logic             clk,
    input logic             rst,
    input logic             res_valid,
    input logic             res_ready,
    input bru_pkg::br_out_t res,
    input logic             upd_valid
);

    timeunit 1ns;
    timeprecision 1ps;

    // held output must not move
    res_stable: assert property (@(posedge clk) disable iff (rst)
        res_valid && !res_ready |=> res_valid && $stable(res))
        else $error("res changed while stalled");

    flag_order: assert property (@(posedge clk) disable iff (rst)
        res_valid && res.res.dir_fail |-> res.res.addr_fail)
        else $error("dir_fail without addr_fail");

    reset_clear: assert property (@(posedge clk) rst |=> !res_valid)
        else $error("res_valid high after reset");

    upd_on_xfer: assert property (@(posedge clk) disable iff (rst)
        upd_valid |-> res_valid && res_ready)
        else $error("predictor update without result transfer");

endmodule

bind bru_top bru_chk u_bru_chk (
    .clk       (clk),
    .rst       (rst),
    .res_valid (res_valid),
    .res_ready (res_ready),
    .res       (res),
    .upd_valid (upd_valid)
);

`default_nettype wire

/* tb_bru.sv */
`default_nettype none

module tb_bru;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int BTB_ENTRIES = 16;
    localparam int IDX_W = $clog2(BTB_ENTRIES);
    localparam int MAX_CASES = 64;
    localparam int TIMEOUT = 100;

    typedef struct packed {
        logic [31:0] pc;
        logic [3:0]  cond;
        logic [31:0] imm;
        logic [31:0] sr1;
        logic [31:0] sr2;
        logic        pred_taken;
        logic [31:0] pred_target;
        logic        taken;
        logic [31:0] target;
        logic        dir_fail;
        logic        addr_fail;
        logic [31:0] redirect_pc;
    } case_t;

    logic              clk;
    logic              rst;
    logic              req_valid;
    logic              req_ready;
    bru_pkg::br_req_t  req;
    logic              res_valid;
    logic              res_ready;
    bru_pkg::br_out_t  res;
    la_isa_pkg::addr_t fetch_pc;
    bru_pkg::bp_pred_t fetch_pred;

    case_t       cases [MAX_CASES];
    int          num_cases;
    logic [31:0] rng;

    // reference BTB
    logic        m_valid [BTB_ENTRIES];
    logic [31:0] m_tag [BTB_ENTRIES];
    logic [31:0] m_tgt [BTB_ENTRIES];
    logic [1:0]  m_ctr [BTB_ENTRIES];

    bru_top #(
        .BTB_ENTRIES (BTB_ENTRIES)
    ) UUT (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .req        (req),
        .res_valid  (res_valid),
        .res_ready  (res_ready),
        .res        (res),
        .fetch_pc   (fetch_pc),
        .fetch_pred (fetch_pred)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAILED at %0d ns: %s got %h expected %h", $time, name, got, exp);
            $display("Simulation FAILED");
            $fatal(1);
        end
    endtask

    task automatic stall(input string what);
        $display("timeout: the %s handshake never completed", what);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    task automatic load_cases();
        int          fd;
        int          cnt;
        string       line;
        logic [31:0] v [12];
        fd = $fopen("bru_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open the case file bru_cases.txt");
            $display("Simulation FAILED");
            $fatal(1);
        end
        num_cases = 0;
        while (!$feof(fd) && num_cases < MAX_CASES) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 0 && line[0] != "#") begin
                cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h", v[0], v[1],
                              v[2], v[3], v[4], v[5], v[6], v[7], v[8], v[9], v[10], v[11]);
                if (cnt == 12) begin
                    cases[num_cases] = {v[0], v[1][3:0], v[2], v[3], v[4], v[5][0], v[6],
                                        v[7][0], v[8], v[9][0], v[10][0], v[11]};
                    num_cases++;
                end
            end
        end
        $fclose(fd);
    endtask

    function automatic bru_pkg::br_req_t make_req(input case_t c);
        bru_pkg::br_req_t r;
        r.pc = c.pc;
        r.imm = c.imm;
        r.sr1 = c.sr1;
        r.sr2 = c.sr2;
        r.uop = '0;
        r.uop[la_isa_pkg::UOP_BR_BIT] = (c.cond != 4'd0);  // NONE marks a non-branch
        r.uop[la_isa_pkg::UOP_COND_LSB +: la_isa_pkg::COND_W] = c.cond;
        r.pred_taken = c.pred_taken;
        r.pred_target = c.pred_target;
        return r;
    endfunction

    task automatic model_update(input case_t c);
        int   idx;
        logic hit;
        idx = c.pc[IDX_W+1:2];
        hit = m_valid[idx] && (m_tag[idx] == (c.pc >> (IDX_W + 2)));
        if (hit) begin
            if (c.taken) begin
                m_tgt[idx] = c.target;
                m_ctr[idx] = (m_ctr[idx] == 2'd3) ? 2'd3 : m_ctr[idx] + 2'd1;
            end else begin
                m_ctr[idx] = (m_ctr[idx] == 2'd0) ? 2'd0 : m_ctr[idx] - 2'd1;
            end
        end else if (c.taken) begin  // allocate weak taken
            m_valid[idx] = 1'b1;
            m_tag[idx] = c.pc >> (IDX_W + 2);
            m_tgt[idx] = c.target;
            m_ctr[idx] = 2'd2;
        end
    endtask

    task automatic check_lookup(input logic [31:0] pc);
        int   idx;
        logic hit;
        idx = pc[IDX_W+1:2];
        hit = m_valid[idx] && (m_tag[idx] == (pc >> (IDX_W + 2)));
        check_val("fetch_pred.hit", fetch_pred.hit, hit);
        check_val("fetch_pred.taken", fetch_pred.taken, hit && (m_ctr[idx] >= 2'd2));
        if (hit) begin
            check_val("fetch_pred.target", fetch_pred.target, m_tgt[idx]);
        end
    endtask

    task automatic check_result(input case_t c);
        check_val("res.pc", res.res.pc, c.pc);
        check_val("res.is_branch", res.res.is_branch, c.cond != 4'd0);
        check_val("res.taken", res.res.taken, c.taken);
        check_val("res.target", res.res.target, c.target);
        check_val("res.dir_fail", res.res.dir_fail, c.dir_fail);
        check_val("res.addr_fail", res.res.addr_fail, c.addr_fail);
        check_val("res.redirect", res.redirect, c.dir_fail | c.addr_fail);
        check_val("res.redirect_pc", res.redirect_pc, c.redirect_pc);
    endtask

    task automatic drive_all();
        int wait_cnt;
        for (int i = 0; i < num_cases; i++) begin
            req_valid <= 1'b1;
            req <= make_req(cases[i]);
            wait_cnt = 0;
            @(posedge clk);
            while (!req_ready) begin
                wait_cnt++;
                if (wait_cnt > TIMEOUT) begin
                    stall("req_valid/req_ready");
                end
                @(posedge clk);
            end
        end
        req_valid <= 1'b0;
    endtask

    task automatic collect_all();
        int   idx;
        int   wait_cnt;
        logic xfer;
        idx = 0;
        wait_cnt = 0;
        while (idx < num_cases) begin
            @(posedge clk);
            xfer = res_valid && res_ready;
            rng = xorshift(rng);
            res_ready <= (rng[1:0] != 2'b00);  // ready about 3 in 4 cycles
            if (xfer) begin
                check_result(cases[idx]);
                if (cases[idx].cond != 4'd0) begin
                    model_update(cases[idx]);
                end
                fetch_pc <= cases[idx].pc;
                idx++;
                wait_cnt = 0;
                @(negedge clk);
                check_lookup(cases[idx-1].pc);
            end else begin
                wait_cnt++;
                if (wait_cnt > TIMEOUT) begin
                    stall("res_valid/res_ready");
                end
            end
        end
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        req_valid = 1'b0;
        req = '0;
        res_ready = 1'b0;
        fetch_pc = '0;
        rng = 32'd49189;
        for (int i = 0; i < BTB_ENTRIES; i++) begin
            m_valid[i] = 1'b0;
        end
        load_cases();
        check_val("num_cases nonzero", num_cases > 0, 1);
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        check_val("res_valid", res_valid, 1'b0);
        fork
            drive_all();
            collect_all();
        join
        @(posedge clk);
        res_ready <= 1'b1;
        @(posedge clk);
        check_val("res_valid", res_valid, 1'b0);  // nothing left over
        // park one result in the output register
        res_ready <= 1'b0;
        req_valid <= 1'b1;
        req <= make_req(cases[0]);
        @(posedge clk);
        check_val("req_ready", req_ready, 1'b1);
        req_valid <= 1'b0;
        @(posedge clk);
        check_val("res_valid", res_valid, 1'b1);  // one cycle latency
        // reset again and look up a trained pc
        rst <= 1'b1;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        for (int i = 0; i < BTB_ENTRIES; i++) begin
            m_valid[i] = 1'b0;
        end
        check_val("res_valid", res_valid, 1'b0);
        fetch_pc <= cases[num_cases-1].pc;
        @(negedge clk);
        check_lookup(cases[num_cases-1].pc);
        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* bru_cases.txt */
# pc cond imm sr1 sr2 pred_taken pred_target | expected: taken target dir_fail addr_fail redirect_pc
# cond: 0 NONE, 3 JIRL, 4 B, 5 BL, 6 BEQ, 7 BNE, 8 BLT, 9 BGE, a BLTU, b BGEU (all values hex)
00001000 6 00000010 00000005 00000005 1 00001040 1 00001040 0 0 00001040
00001004 6 00000010 00000005 00000006 0 00000000 0 00001044 0 0 00001008
00001008 7 fffffffc 00000001 00000002 0 00000000 1 00000ff8 1 1 00000ff8
0000100c 7 00000008 ffffffff ffffffff 1 0000102c 0 0000102c 1 1 00001010
00001010 8 00000004 ffffffff 00000001 1 00001020 1 00001020 0 0 00001020
00001014 a 00000004 ffffffff 00000001 0 00000000 0 00001024 0 0 00001018
00001018 9 00000100 00000001 80000000 1 00001400 1 00001418 0 1 00001418
0000101c b 00000100 00000001 80000000 0 00000000 0 0000141c 0 0 00001020
00001020 8 ffffff00 00000007 00000007 0 00000000 0 00000c20 0 0 00001024
00001024 9 ffffff00 00000007 00000007 0 00000000 1 00000c24 1 1 00000c24
00001028 a 00000020 00000001 ffffffff 1 000010a8 1 000010a8 0 0 000010a8
0000102c b 00000002 80000000 80000000 1 00001034 1 00001034 0 0 00001034
00002000 3 00000004 00008000 00000000 1 00008000 1 00008010 0 1 00008010
00002004 3 fffffffe 00008010 00000000 0 00000000 1 00008008 1 1 00008008
00013000 4 fffff000 00000000 00000000 1 0000f000 1 0000f000 0 0 0000f000
00003004 5 00040000 00000000 00000000 0 00000000 1 00103004 1 1 00103004
00004000 0 00000010 00000000 00000000 0 00000000 0 00004040 0 0 00004004
00005000 6 00000008 00000003 00000003 1 00005020 1 00005020 0 0 00005020
00005000 6 00000008 00000003 00000003 1 00005020 1 00005020 0 0 00005020
00005000 6 00000008 00000003 00000003 1 00005020 1 00005020 0 0 00005020
00005000 6 00000008 00000003 00000004 1 00005020 0 00005020 1 1 00005004
00005000 6 00000008 00000003 00000004 1 00005020 0 00005020 1 1 00005004

/* sources.f */
la_isa_pkg.sv
bru_pkg.sv
branch_unit.sv
redirect_ctrl.sv
branch_predictor.sv
bru_top.sv
bru_chk.sv
tb_bru.sv

/* Bender.yml */
package:
  name: bru

sources:
  - files:
      - la_isa_pkg.sv
      - bru_pkg.sv
      - branch_unit.sv
      - redirect_ctrl.sv
      - branch_predictor.sv
      - bru_top.sv
  - target: test
    files:
      - bru_chk.sv
      - tb_bru.sv
